/* sources.f */
+incdir+.
cpu_pkg.sv
block_ram.sv
mmu_page_table.sv
mmu_walker.sv
core_control.sv
cpu_top.sv
cpu_checker.sv
tb_cpu.sv

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module tb_cpu;

  logic                       clka = 1'b0;
  logic                       rst;
  logic                       run;
  logic                       load_valid;
  logic                       load_ready;
  cpu_pkg::load_req_t         load;
  logic                       retire_valid;
  logic                       retire_ready;
  cpu_pkg::retire_t           retire;
  logic                       halted;

  logic [31:0]                lfsr = 32'hf579_92bd;
  logic [`CPU_DATA_W-1:0]     ram_model [2**`CPU_ADDR_W];  // physical copy as loaded
  logic [`CPU_DATA_W-1:0]     reg_model [`CPU_NUM_REGS];
  logic [`CPU_PAGE_NUM_W-1:0] page_map [`CPU_NUM_PAGES];   // logical to physical
  logic                       page_used [`CPU_NUM_PAGES];
  int                         next_page = 1;               // next physical page handed out
  logic [`CPU_ADDR_W-1:0]     model_pc = `CPU_START_PC;
  int                         prog_words = 0;
  int                         n_instr = 0;
  int                         cycle_limit = 0;
  int                         cycles = 0;
  int                         value_errors = 0;
  int                         other_errors = 0;
  int                         n_retired = 0;

  cpu_top dut_i (
    .clka, .rst, .run, .load_valid, .load_ready, .load,
    .retire_valid, .retire_ready, .retire, .halted
  );

  bind cpu_top cpu_checker checker_i (
    .clka, .rst, .run, .load_ready, .retire_valid, .retire_ready, .retire, .halted
  );

  always #20 clka = ~clka;  // 40 ns

  always @(posedge clka) begin
    cycles <= cycles + 1;
    if (cycles > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // galois form with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[14:0], lfsr[0]};  // one step per bit
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic logic [`CPU_ADDR_W-1:0] pick_data_addr();
    logic [`CPU_PAGE_NUM_W-1:0] lp;
    lp = 4'(rand_bits(4));
    if (lp == 0) lp = 4'd15;  // keep data off the program page
    return {lp, 6'(rand_bits(6))};
  endfunction

  // first touch takes the next physical page in order
  function automatic logic [`CPU_ADDR_W-1:0] model_xlate(input logic [`CPU_ADDR_W-1:0] la);
    logic [`CPU_PAGE_NUM_W-1:0] lp;
    lp = la[9:6];
    if (!page_used[lp]) begin
      page_used[lp] = 1'b1;
      page_map[lp]  = 4'(next_page);
      next_page++;
    end
    return {page_map[lp], la[5:0]};
  endfunction

  task automatic emit(input logic [7:0] op, input logic [3:0] r, input logic [15:0] arg);
    ram_model[prog_words]     = {op, 4'(rand_bits(4)), r};  // upper reg nibble is junk
    ram_model[prog_words + 1] = arg;
    prog_words += 2;
    n_instr++;
  endtask

  // executes one instruction on the model state
  task automatic model_step(output cpu_pkg::retire_t exp);
    logic [`CPU_DATA_W-1:0] w1;
    logic [`CPU_DATA_W-1:0] w2;
    logic [3:0]             r;
    w1  = ram_model[model_xlate(model_pc)];
    w2  = ram_model[model_xlate(model_pc + 1'b1)];
    r   = w1[3:0];
    exp = '{pc: model_pc, opcode: w1[15:8], reg_idx: r, result: '0};
    model_pc = model_pc + 2'd2;
    case (w1[15:8])
      cpu_pkg::op_jmp: begin
        model_pc   = w2[9:0];
        exp.result = 16'(w2[9:0]);
      end
      cpu_pkg::op_ram2reg: begin
        reg_model[r] = ram_model[model_xlate(w2[9:0])];
        exp.result   = reg_model[r];
      end
      cpu_pkg::op_reg2ram: begin
        ram_model[model_xlate(w2[9:0])] = reg_model[r];
        exp.result = reg_model[r];
      end
      cpu_pkg::op_num2reg:   reg_model[r] = w2;
      cpu_pkg::op_reg_plus:  reg_model[r] = reg_model[r] + w2;  // wraps
      cpu_pkg::op_reg_minus: reg_model[r] = reg_model[r] - w2;
      default: ;
    endcase
    if (w1[15:8] inside {cpu_pkg::op_num2reg, cpu_pkg::op_reg_plus, cpu_pkg::op_reg_minus})
      exp.result = reg_model[r];
  endtask

  task automatic check(input string name, input logic [63:0] expected,
                       input logic [63:0] actual);
    if (expected !== actual) begin
      $display("** Error: %s expected %h, got %h", name, expected, actual);
      value_errors++;
    end
  endtask

  initial begin
    cpu_pkg::retire_t       exp;
    cpu_pkg::retire_t       held;
    logic [`CPU_ADDR_W-1:0] first_addr;
    logic [`CPU_ADDR_W-1:0] addr;
    logic                   stalled;
    logic                   exited;
    logic                   extra_retire;
    rst          = 1'b0;
    run          = 1'b0;
    load_valid   = 1'b0;
    load         = '0;
    retire_ready = 1'b0;
    for (int p = 0; p < `CPU_NUM_PAGES; p++) begin
      page_used[p] = (p == 0);  // lpage 0 lives in page 0
      page_map[p]  = '0;
    end
    for (int r = 0; r < `CPU_NUM_REGS; r++) reg_model[r] = '0;
    for (int a = 0; a < 2**`CPU_ADDR_W; a++) ram_model[a] = rand_bits(16);

    // program in page 0
    for (int i = 0; i < 4; i++) emit(cpu_pkg::op_num2reg, 4'(rand_bits(4)), rand_bits(16));
    for (int i = 0; i < 4; i++)
      emit(i[0] ? cpu_pkg::op_reg_minus : cpu_pkg::op_reg_plus, 4'(rand_bits(4)), rand_bits(16));
    first_addr = pick_data_addr();
    emit(cpu_pkg::op_ram2reg, 4'(rand_bits(4)), {6'(rand_bits(6)), first_addr});
    for (int i = 0; i < 2; i++)
      emit(cpu_pkg::op_ram2reg, 4'(rand_bits(4)), {6'(rand_bits(6)), pick_data_addr()});
    addr = pick_data_addr();
    emit(cpu_pkg::op_reg2ram, 4'd3, {6'd0, addr});  // store then reload
    emit(cpu_pkg::op_ram2reg, 4'd9, {6'd0, addr});
    emit(cpu_pkg::op_ram2reg, 4'd5, {6'd0, first_addr[9:6], 6'(rand_bits(6))});  // mapped
    emit(cpu_pkg::op_ram2reg, 4'd6, {6'd0, pick_data_addr()});
    emit(cpu_pkg::op_jmp, 4'd0, 16'(prog_words + 4));  // over the next one
    emit(cpu_pkg::op_num2reg, 4'd3, 16'hdead);
    emit(8'h40 | 8'(rand_bits(4)), 4'd2, rand_bits(16));  // unknown opcode
    emit(cpu_pkg::op_reg_plus, 4'd9, rand_bits(16));
    emit(cpu_pkg::op_exit, 4'd0, 16'h0);
    cycle_limit = 2**`CPU_ADDR_W + 200 * n_instr + 100;  // plus reset and exit windows

    repeat (2) @(posedge clka);
    rst <= 1'b1;
    for (int a = 0; a < 2**`CPU_ADDR_W; a++) begin
      load_valid <= 1'b1;
      load       <= '{addr: `CPU_ADDR_W'(a), data: ram_model[a]};
      @(posedge clka);
      while (!load_ready) @(posedge clka);
    end
    load_valid   <= 1'b0;
    run          <= 1'b1;
    retire_ready <= 1'b1;
    stalled = 1'b0;
    exited  = 1'b0;
    while (!exited) begin
      @(posedge clka);
      if (stalled) begin
        check("retire_valid", 1, retire_valid);
        check("retire", held, retire);  // frozen under back-pressure
      end
      check("load_ready", 0, load_ready);  // host port closed while running
      stalled = retire_valid && !retire_ready;
      held    = retire;
      if (retire_valid && retire_ready) begin
        model_step(exp);
        check("retire.pc", exp.pc, retire.pc);
        check("retire.opcode", exp.opcode, retire.opcode);
        check("retire.reg_idx", exp.reg_idx, retire.reg_idx);
        check("retire.result", exp.result, retire.result);
        n_retired++;
        exited = (exp.opcode == cpu_pkg::op_exit);
      end
      retire_ready <= (rand_bits(2) != 16'd0);  // stall about one in four
    end

    extra_retire = 1'b0;
    for (int i = 0; i < 30; i++) begin
      @(posedge clka);
      if (retire_valid) extra_retire = 1'b1;
    end
    check("halted", 1, halted);
    check("retire count", n_instr - 1, n_retired);  // jmp skips one
    if (extra_retire) begin
      $display("a retire appeared after exit");
      other_errors++;
    end
    run <= 1'b0;
    for (int i = 0; i < 10 && halted; i++) @(posedge clka);
    check("halted", 0, halted);

    $display("value errors: %0d, other errors: %0d, assertion failures: %0d, retired: %0d",
             value_errors, other_errors, dut_i.checker_i.assert_fails, n_retired);
    if (value_errors == 0 && other_errors == 0 && dut_i.checker_i.assert_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
  input wire                    clka,
  input wire                    rst,
  input wire                    run,
  input wire                    load_ready,
  input wire                    retire_valid,
  input wire                    retire_ready,
  input wire cpu_pkg::retire_t  retire,
  input wire                    halted
);

  int assert_fails = 0;  // failed assertions so far

  // payload frozen until the host takes it
  retire_stable: assert property (@(posedge clka) disable iff (!rst)
    (retire_valid && !retire_ready) |=> (retire_valid && $stable(retire)))
    else begin
      assert_fails++;
      $error("retire payload changed while the host stalled it");
    end

  // host loads only while stopped
  load_blocked: assert property (@(posedge clka) disable iff (!rst)
    run |-> !load_ready)
    else begin
      assert_fails++;
      $error("load_ready was high while run was high");
    end

  no_retire_halted: assert property (@(posedge clka) disable iff (!rst)
    halted |-> !retire_valid)
    else begin
      assert_fails++;
      $error("retire_valid was high while halted");
    end

endmodule

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module cpu_top (
  input  wire                      clka,
  input  wire                      rst,
  input  wire                      run,
  input  wire                      load_valid,
  output logic                     load_ready,
  input  wire cpu_pkg::load_req_t  load,
  output logic                     retire_valid,
  input  wire                      retire_ready,
  output cpu_pkg::retire_t         retire,
  output logic                     halted
);

  logic                       xlat_start;
  logic [`CPU_ADDR_W-1:0]     xlat_addr;   // logical
  logic                       xlat_done;
  logic [`CPU_ADDR_W-1:0]     phys_addr;
  logic [`CPU_PAGE_NUM_W-1:0] rd_index;
  cpu_pkg::page_entry_t       rd_entry;
  logic                       alloc;
  logic [`CPU_PAGE_NUM_W-1:0] alloc_tail;
  logic [`CPU_PAGE_NUM_W-1:0] alloc_lpage;
  logic [`CPU_PAGE_NUM_W-1:0] alloc_page;
  logic                       ram_wr_en;
  logic [`CPU_ADDR_W-1:0]     ram_wr_addr;
  logic [`CPU_DATA_W-1:0]     ram_wr_data;
  logic [`CPU_ADDR_W-1:0]     ram_rd_addr;
  logic [`CPU_DATA_W-1:0]     ram_rd_data;

  core_control u_core (
    .clka, .rst, .run, .load_valid, .load_ready, .load,
    .retire_valid, .retire_ready, .retire, .halted,
    .xlat_start, .xlat_addr, .xlat_done, .phys_addr,
    .ram_wr_en, .ram_wr_addr, .ram_wr_data, .ram_rd_addr, .ram_rd_data
  );

  mmu_walker u_walker (
    .clka, .rst, .xlat_start, .xlat_addr, .xlat_done, .phys_addr,
    .rd_index, .rd_entry, .alloc, .alloc_tail, .alloc_lpage, .alloc_page
  );

  mmu_page_table u_page_table (
    .clka, .rst, .rd_index, .rd_entry, .alloc, .alloc_tail, .alloc_lpage, .alloc_page
  );

  block_ram u_ram (
    .clka,
    .wr_en   (ram_wr_en),
    .wr_addr (ram_wr_addr),
    .wr_data (ram_wr_data),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_rd_data)
  );

endmodule

`default_nettype wire

/* core_control.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module core_control (
  input  wire                         clka,
  input  wire                         rst,
  input  wire                         run,
  input  wire                         load_valid,
  output logic                        load_ready,
  input  wire cpu_pkg::load_req_t     load,
  output logic                        retire_valid,
  input  wire                         retire_ready,
  output cpu_pkg::retire_t            retire,
  output logic                        halted,
  output logic                        xlat_start,
  output logic [`CPU_ADDR_W-1:0]      xlat_addr,
  input  wire                         xlat_done,
  input  wire [`CPU_ADDR_W-1:0]       phys_addr,
  output logic                        ram_wr_en,
  output logic [`CPU_ADDR_W-1:0]      ram_wr_addr,
  output logic [`CPU_DATA_W-1:0]      ram_wr_data,
  output logic [`CPU_ADDR_W-1:0]      ram_rd_addr,
  input  wire [`CPU_DATA_W-1:0]       ram_rd_data
);

  cpu_pkg::core_state_t      state;
  logic [`CPU_ADDR_W-1:0]    pc;        // next word to fetch
  logic [`CPU_ADDR_W-1:0]    inst_pc;   // word 1 of current instruction
  logic [7:0]                inst_op;
  logic [`CPU_REG_NUM_W-1:0] inst_reg;
  logic [`CPU_DATA_W-1:0]    inst_arg;  // word 2, value or address
  logic [`CPU_DATA_W-1:0]    regs [`CPU_NUM_REGS];
  logic                      rst_done;  // first clock after reset seen
  logic                      load_fire;
  logic                      in_xlat;

  assign in_xlat = (state == cpu_pkg::st_fetch1_xlat) || (state == cpu_pkg::st_fetch2_xlat) ||
                   (state == cpu_pkg::st_read_xlat) || (state == cpu_pkg::st_write_xlat);

  // host owns the write port while stopped
  assign load_ready  = rst_done && !run;
  assign load_fire   = load_valid && load_ready;
  assign ram_wr_en   = load_fire || (run && state == cpu_pkg::st_write);
  assign ram_wr_addr = load_fire ? load.addr : phys_addr;
  assign ram_wr_data = load_fire ? load.data : regs[inst_reg];
  assign ram_rd_addr = phys_addr;  // read issued on the done cycle

  always_ff @(posedge clka) begin
    if (!rst) begin
      state        <= cpu_pkg::st_idle;
      pc           <= `CPU_START_PC;
      rst_done     <= 1'b0;
      retire_valid <= 1'b0;
      halted       <= 1'b0;
      xlat_start   <= 1'b0;
      for (int r = 0; r < `CPU_NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else begin
      rst_done   <= 1'b1;
      xlat_start <= 1'b0;  // pulse
      if (!run && !in_xlat) begin
        // stop, never while a translation is in flight
        state        <= cpu_pkg::st_idle;
        retire_valid <= 1'b0;
        halted       <= 1'b0;
      end else begin
        case (state)
          cpu_pkg::st_idle: begin  // run rose
            pc         <= `CPU_START_PC;
            inst_pc    <= `CPU_START_PC;
            xlat_start <= 1'b1;
            xlat_addr  <= `CPU_START_PC;
            state      <= cpu_pkg::st_fetch1_xlat;
          end
          cpu_pkg::st_fetch1_xlat: if (xlat_done) state <= cpu_pkg::st_fetch1;
          cpu_pkg::st_fetch1: begin
            inst_op    <= ram_rd_data[15:8];
            inst_reg   <= ram_rd_data[`CPU_REG_NUM_W-1:0];  // low bits of reg byte
            pc         <= pc + 1'b1;
            xlat_start <= 1'b1;
            xlat_addr  <= pc + 1'b1;
            state      <= cpu_pkg::st_fetch2_xlat;
          end
          cpu_pkg::st_fetch2_xlat: if (xlat_done) state <= cpu_pkg::st_fetch2;
          cpu_pkg::st_fetch2: begin
            inst_arg <= ram_rd_data;
            pc       <= pc + 1'b1;
            state    <= cpu_pkg::st_exec;
          end
          cpu_pkg::st_exec: begin
            retire.pc      <= inst_pc;
            retire.opcode  <= inst_op;
            retire.reg_idx <= inst_reg;
            retire.result  <= '0;  // no-op and exit
            retire_valid   <= 1'b1;
            state          <= cpu_pkg::st_retire;
            case (inst_op)
              cpu_pkg::op_jmp: begin
                pc            <= inst_arg[`CPU_ADDR_W-1:0];
                retire.result <= `CPU_DATA_W'(inst_arg[`CPU_ADDR_W-1:0]);
              end
              cpu_pkg::op_ram2reg, cpu_pkg::op_reg2ram: begin
                retire_valid <= 1'b0;  // data access first
                xlat_start   <= 1'b1;
                xlat_addr    <= inst_arg[`CPU_ADDR_W-1:0];
                state        <= (inst_op == cpu_pkg::op_ram2reg) ? cpu_pkg::st_read_xlat
                                                                 : cpu_pkg::st_write_xlat;
              end
              cpu_pkg::op_num2reg: begin
                regs[inst_reg] <= inst_arg;
                retire.result  <= inst_arg;
              end
              cpu_pkg::op_reg_plus: begin
                regs[inst_reg] <= regs[inst_reg] + inst_arg;  // wraps mod 2^16
                retire.result  <= regs[inst_reg] + inst_arg;
              end
              cpu_pkg::op_reg_minus: begin
                regs[inst_reg] <= regs[inst_reg] - inst_arg;
                retire.result  <= regs[inst_reg] - inst_arg;
              end
              default: ;  // exit and unknown, nothing to do
            endcase
          end
          cpu_pkg::st_read_xlat: if (xlat_done) state <= cpu_pkg::st_read;
          cpu_pkg::st_read: begin
            regs[inst_reg] <= ram_rd_data;
            retire.result  <= ram_rd_data;
            retire_valid   <= 1'b1;
            state          <= cpu_pkg::st_retire;
          end
          cpu_pkg::st_write_xlat: if (xlat_done) state <= cpu_pkg::st_write;
          cpu_pkg::st_write: begin  // store goes out on the port this cycle
            retire.result <= regs[inst_reg];
            retire_valid  <= 1'b1;
            state         <= cpu_pkg::st_retire;
          end
          cpu_pkg::st_retire: begin
            if (retire_ready) begin  // payload held until taken
              retire_valid <= 1'b0;
              if (retire.opcode == cpu_pkg::op_exit) begin
                halted <= 1'b1;
                state  <= cpu_pkg::st_halted;
              end else begin
                inst_pc    <= pc;
                xlat_start <= 1'b1;
                xlat_addr  <= pc;
                state      <= cpu_pkg::st_fetch1_xlat;
              end
            end
          end
          cpu_pkg::st_halted: ;  // wait for run to fall
          default: state <= cpu_pkg::st_idle;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

/* mmu_walker.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module mmu_walker (
  input  wire                         clka,
  input  wire                         rst,
  input  wire                         xlat_start,
  input  wire [`CPU_ADDR_W-1:0]       xlat_addr,
  output logic                        xlat_done,
  output logic [`CPU_ADDR_W-1:0]      phys_addr,
  output logic [`CPU_PAGE_NUM_W-1:0]  rd_index,
  input  wire cpu_pkg::page_entry_t   rd_entry,
  output logic                        alloc,
  output logic [`CPU_PAGE_NUM_W-1:0]  alloc_tail,
  output logic [`CPU_PAGE_NUM_W-1:0]  alloc_lpage,
  input  wire [`CPU_PAGE_NUM_W-1:0]   alloc_page
);

  cpu_pkg::walk_state_t       state;
  logic [`CPU_PAGE_NUM_W-1:0] req_lpage;    // page being looked up
  logic [`CPU_PAGE_W-1:0]     req_off;      // offset kept across the walk
  logic [`CPU_PAGE_NUM_W-1:0] cur_page;     // chain entry visited now
  logic [`CPU_PAGE_NUM_W-1:0] cache_lpage;  // last translation
  logic [`CPU_PAGE_NUM_W-1:0] cache_ppage;
  logic [`CPU_PAGE_NUM_W-1:0] start_lpage;

  assign start_lpage = xlat_addr[`CPU_ADDR_W-1:`CPU_PAGE_W];
  assign rd_index    = cur_page;
  assign alloc       = (state == cpu_pkg::ws_alloc);  // one cycle, table answers at once
  assign alloc_tail  = cur_page;                      // walk stopped at the tail
  assign alloc_lpage = req_lpage;

  always_ff @(posedge clka) begin
    if (!rst) begin
      state       <= cpu_pkg::ws_idle;
      xlat_done   <= 1'b0;
      cache_lpage <= '0;  // lpage 0 always sits in page 0
      cache_ppage <= '0;
    end else begin
      xlat_done <= 1'b0;  // strobe
      case (state)
        cpu_pkg::ws_idle: begin
          if (xlat_start) begin
            req_lpage <= start_lpage;
            req_off   <= xlat_addr[`CPU_PAGE_W-1:0];
            if (start_lpage == cache_lpage) begin
              xlat_done <= 1'b1;  // hit, done next cycle
              phys_addr <= {cache_ppage, xlat_addr[`CPU_PAGE_W-1:0]};
            end else begin
              cur_page <= '0;     // chain head
              state    <= cpu_pkg::ws_walk;
            end
          end
        end
        cpu_pkg::ws_walk: begin
          if (rd_entry.lpage == req_lpage) begin
            xlat_done   <= 1'b1;
            phys_addr   <= {cur_page, req_off};
            cache_lpage <= req_lpage;
            cache_ppage <= cur_page;
            state       <= cpu_pkg::ws_idle;
          end else if (rd_entry.next == cur_page) begin
            state <= cpu_pkg::ws_alloc;  // end of chain, page missing
          end else begin
            cur_page <= rd_entry.next;   // one entry per cycle
          end
        end
        cpu_pkg::ws_alloc: begin
          xlat_done   <= 1'b1;
          phys_addr   <= {alloc_page, req_off};
          cache_lpage <= req_lpage;
          cache_ppage <= alloc_page;
          state       <= cpu_pkg::ws_idle;
        end
        default: state <= cpu_pkg::ws_idle;
      endcase
    end
  end

endmodule

`default_nettype wire

/* mmu_page_table.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module mmu_page_table (
  input  wire                         clka,
  input  wire                         rst,
  input  wire [`CPU_PAGE_NUM_W-1:0]   rd_index,
  output cpu_pkg::page_entry_t        rd_entry,
  input  wire                         alloc,
  input  wire [`CPU_PAGE_NUM_W-1:0]   alloc_tail,
  input  wire [`CPU_PAGE_NUM_W-1:0]   alloc_lpage,
  output logic [`CPU_PAGE_NUM_W-1:0]  alloc_page
);

  cpu_pkg::page_entry_t       chain [`CPU_NUM_PAGES];  // one entry per physical page
  logic [`CPU_PAGE_NUM_W-1:0] next_free;               // lowest never-used page

  assign rd_entry   = chain[rd_index];  // walker reads combinationally
  assign alloc_page = next_free;        // page handed out this cycle

  always_ff @(posedge clka) begin
    if (!rst) begin
      // every page a lone end, page 0 holds lpage 0
      for (int p = 0; p < `CPU_NUM_PAGES; p++) begin
        chain[p] <= '{next: `CPU_PAGE_NUM_W'(p), lpage: '0};
      end
      next_free <= `CPU_PAGE_NUM_W'(1);
    end else if (alloc) begin
      chain[alloc_tail].next <= next_free;                          // link old tail
      chain[next_free]       <= '{next: next_free, lpage: alloc_lpage}; // new end
      next_free              <= next_free + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* block_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cpu_config.svh"

module block_ram (
  input  wire                    clka,
  input  wire                    wr_en,
  input  wire  [`CPU_ADDR_W-1:0] wr_addr,
  input  wire  [`CPU_DATA_W-1:0] wr_data,
  input  wire  [`CPU_ADDR_W-1:0] rd_addr,
  output logic [`CPU_DATA_W-1:0] rd_data
);

  logic [`CPU_DATA_W-1:0] mem [2**`CPU_ADDR_W];  // program and data, 1024 words

  always_ff @(posedge clka) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;  // visible from the next edge on
    end
    rd_data <= mem[rd_addr];    // one cycle read latency
  end

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none
`include "cpu_config.svh"

package cpu_pkg;

  // instruction opcodes, upper byte of word 1
  typedef enum logic [7:0] {
    op_jmp       = 8'd1,
    op_ram2reg   = 8'd2,
    op_reg2ram   = 8'd3,
    op_num2reg   = 8'd4,
    op_reg_plus  = 8'd5,
    op_reg_minus = 8'd6,
    op_exit      = 8'd17   // anything not listed is a no-op
  } opcode_t;

  // control states, the _xlat ones wait for the mmu
  typedef enum logic [3:0] {
    st_idle,
    st_fetch1_xlat,
    st_fetch1,
    st_fetch2_xlat,
    st_fetch2,
    st_exec,
    st_read_xlat,
    st_read,
    st_write_xlat,
    st_write,
    st_retire,
    st_halted
  } core_state_t;

  typedef enum logic [1:0] {
    ws_idle,
    ws_walk,
    ws_alloc
  } walk_state_t;

  typedef struct packed {
    logic [`CPU_ADDR_W-1:0] addr;   // physical
    logic [`CPU_DATA_W-1:0] data;
  } load_req_t;

  typedef struct packed {
    logic [`CPU_ADDR_W-1:0]    pc;       // logical pc of word 1
    logic [7:0]                opcode;   // raw byte, unknown ones too
    logic [`CPU_REG_NUM_W-1:0] reg_idx;
    logic [`CPU_DATA_W-1:0]    result;
  } retire_t;

  typedef struct packed {
    logic [`CPU_PAGE_NUM_W-1:0] next;    // points to itself at chain end
    logic [`CPU_PAGE_NUM_W-1:0] lpage;
  } page_entry_t;

endpackage

`default_nettype wire

/* cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// address and data widths
`define CPU_ADDR_W 10          // logical and physical word address
`define CPU_DATA_W 16          // one RAM word

// page geometry, 16 pages of 64 words
`define CPU_PAGE_W 6           // in-page offset bits
`define CPU_PAGE_NUM_W 4       // page number bits
`define CPU_NUM_PAGES 16       // physical pages in RAM

// register file
`define CPU_REG_NUM_W 4        // low bits of the register byte
`define CPU_NUM_REGS 16

// first instruction after run rises
`define CPU_START_PC 10'd0

`endif
